// ==== lsu_pkg.sv ====
// load/store types for rv64; store codes share low bits with loads, only funct3[1:0] sets the size
package lsu_pkg;

  typedef logic [63:0] dword_t;
  typedef logic [2:0]  byte_off_t;

  // load encodings as in the rv64i opcode map
  typedef enum logic [2:0] {
    F3_LB  = 3'b000,
    F3_LH  = 3'b001,
    F3_LW  = 3'b010,
    F3_LD  = 3'b011,
    F3_LBU = 3'b100,
    F3_LHU = 3'b101,
    F3_LWU = 3'b110
  } funct3_t;

  // stores reuse the low two bits of the matching load
  localparam funct3_t F3_SB = F3_LB;
  localparam funct3_t F3_SH = F3_LH;
  localparam funct3_t F3_SW = F3_LW;
  localparam funct3_t F3_SD = F3_LD;

  typedef enum logic [1:0] {
    SZ_BYTE  = 2'b00,
    SZ_HALF  = 2'b01,
    SZ_WORD  = 2'b10,
    SZ_DWORD = 2'b11
  } size_t;

  function automatic logic [3:0] bytes_of(input size_t sz);
    case (sz)
      SZ_BYTE: return 4'd1;
      SZ_HALF: return 4'd2;
      SZ_WORD: return 4'd4;
      default: return 4'd8;
    endcase
  endfunction

  function automatic dword_t mask_of(input size_t sz);
    case (sz)
      SZ_BYTE: return 64'h0000_0000_0000_00ff;
      SZ_HALF: return 64'h0000_0000_0000_ffff;
      SZ_WORD: return 64'h0000_0000_ffff_ffff;
      default: return 64'hffff_ffff_ffff_ffff;
    endcase
  endfunction

endpackage

// ==== mem_req_if.sv ====
// aligned two-word request from align to ram; idx2 wraps at the ram depth
interface mem_req_if import lsu_pkg::*; #(
  parameter int DEPTH_LOG2 = 8
) ();

  logic                  ren;
  logic                  wen;
  // second word touched by a crossing access
  logic                  unit2;
  logic [DEPTH_LOG2-1:0] idx1;
  logic [DEPTH_LOG2-1:0] idx2;
  dword_t                wdata1;
  dword_t                wdata2;
  // bit masks, always whole bytes
  dword_t                wmask1;
  dword_t                wmask2;
  byte_off_t             off;
  funct3_t               funct3;

  modport src (
    output ren, wen, unit2,
    output idx1, idx2,
    output wdata1, wdata2, wmask1, wmask2,
    output off, funct3
  );

  modport dst (
    input ren, wen, unit2,
    input idx1, idx2,
    input wdata1, wdata2, wmask1, wmask2,
    input off, funct3
  );

endinterface

// ==== mem_align.sv ====
// stage 1; expects BASE_ADDR 8-byte aligned, out-of-range addresses are not handled in logic
module mem_align import lsu_pkg::*; #(
  parameter dword_t BASE_ADDR  = 64'h0000_0000_8000_0000,
  parameter int     DEPTH_LOG2 = 8
) (
  input  logic          clk,
  input  logic          i_rst,
  input  dword_t        i_addr,
  input  funct3_t       i_funct3,
  input  logic          i_ren,
  input  logic          i_wen,
  input  dword_t        i_wdata,
  mem_req_if.src        o_req
);

  dword_t                addr_rel;
  logic [DEPTH_LOG2-1:0] idx1;
  byte_off_t             off;
  size_t                 size;
  logic [3:0]            nbytes;
  logic                  unit2;
  logic [5:0]            sh1;
  logic [6:0]            sh2;
  dword_t                mask;
  dword_t                wdata1;
  dword_t                wdata2;
  dword_t                wmask1;
  dword_t                wmask2;

  assign addr_rel = i_addr - BASE_ADDR;
  assign idx1     = addr_rel[DEPTH_LOG2+2:3];
  assign off      = i_addr[2:0];
  assign size     = size_t'(i_funct3[1:0]);
  assign nbytes   = bytes_of(size);

  // crossing when the last byte lands past byte 7
  assign unit2 = ({1'b0, off} + nbytes) > 4'd8;

  assign sh1  = {off, 3'b000};
  assign sh2  = 7'd64 - {1'b0, sh1};
  assign mask = mask_of(size);

  // low part into word 1, spill-over into word 2
  assign wdata1 = i_wdata << sh1;
  assign wdata2 = unit2 ? (i_wdata >> sh2) : '0;
  assign wmask1 = i_wen ? (mask << sh1) : '0;
  assign wmask2 = (i_wen && unit2) ? (mask >> sh2) : '0;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_req.ren <= 1'b0;
      o_req.wen <= 1'b0;
    end else begin
      o_req.ren <= i_ren;
      o_req.wen <= i_wen;
    end
  end

  always_ff @(posedge clk) begin
    o_req.unit2  <= unit2;
    o_req.idx1   <= idx1;
    o_req.idx2   <= idx1 + 1'b1;
    o_req.wdata1 <= wdata1;
    o_req.wdata2 <= wdata2;
    o_req.wmask1 <= wmask1;
    o_req.wmask2 <= wmask2;
    o_req.off    <= off;
    o_req.funct3 <= i_funct3;
  end

  // a single access per cycle from the core
  a_ren_wen_excl: assert property (@(posedge clk) disable iff (i_rst)
    !(i_ren && i_wen));

  // start address must fall inside the ram window
  a_addr_in_range: assert property (@(posedge clk) disable iff (i_rst)
    (i_ren || i_wen) |-> (addr_rel[63:DEPTH_LOG2+3] == '0));

endmodule

// ==== dual_word_ram.sv ====
// stage 2; no init contents, both words written and read in one cycle, idx1 != idx2 assumed
module dual_word_ram import lsu_pkg::*; #(
  parameter int DEPTH_LOG2 = 8
) (
  input  logic      clk,
  input  logic      i_rst,
  mem_req_if.dst    i_req,
  output logic      o_rvalid,
  output dword_t    o_rdata1,
  output dword_t    o_rdata2,
  output byte_off_t o_off,
  output funct3_t   o_funct3
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  dword_t mem [DEPTH];

  // byte lanes enabled from the low bit of each mask byte
  always_ff @(posedge clk) begin
    if (i_req.wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_req.wmask1[8*b]) begin
          mem[i_req.idx1][8*b +: 8] <= i_req.wdata1[8*b +: 8];
        end
        if (i_req.wmask2[8*b]) begin
          mem[i_req.idx2][8*b +: 8] <= i_req.wdata2[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= i_req.ren;
    end
  end

  // read data and load control move together
  always_ff @(posedge clk) begin
    if (i_req.ren) begin
      o_rdata1 <= mem[i_req.idx1];
      o_rdata2 <= i_req.unit2 ? mem[i_req.idx2] : '0;
      o_off    <= i_req.off;
      o_funct3 <= i_req.funct3;
    end
  end

  // masks come from align gated by the store strobe
  a_mask_needs_wen: assert property (@(posedge clk) disable iff (i_rst)
    ((i_req.wmask1 != '0) || (i_req.wmask2 != '0)) |-> i_req.wen);

endmodule

// ==== load_extract.sv ====
// stage 3; result holds between loads, unknown funct3 returns zero
module load_extract import lsu_pkg::*; (
  input  logic      clk,
  input  logic      i_rst,
  input  logic      i_rvalid,
  input  dword_t    i_rdata1,
  input  dword_t    i_rdata2,
  input  byte_off_t i_off,
  input  funct3_t   i_funct3,
  output logic      o_rvalid,
  output dword_t    o_rdata
);

  logic [5:0] sh1;
  logic [6:0] sh2;
  dword_t     merged;
  dword_t     ext;

  assign sh1 = {i_off, 3'b000};
  assign sh2 = 7'd64 - {1'b0, sh1};

  // upper bytes of word 1 joined with the low bytes of word 2
  assign merged = (i_off == '0) ? i_rdata1 :
                  ((i_rdata1 >> sh1) | (i_rdata2 << sh2));

  always_comb begin
    case (i_funct3)
      F3_LB:   ext = {{56{merged[7]}}, merged[7:0]};
      F3_LH:   ext = {{48{merged[15]}}, merged[15:0]};
      F3_LW:   ext = {{32{merged[31]}}, merged[31:0]};
      F3_LD:   ext = merged;
      F3_LBU:  ext = {56'd0, merged[7:0]};
      F3_LHU:  ext = {48'd0, merged[15:0]};
      F3_LWU:  ext = {32'd0, merged[31:0]};
      default: ext = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_rvalid <= 1'b0;
      o_rdata  <= '0;
    end else begin
      o_rvalid <= i_rvalid;
      if (i_rvalid) begin
        o_rdata <= ext;
      end
    end
  end

endmodule

// ==== lsu_top.sv ====
// load/store path, 3-cycle load latency, no back-pressure, one access per cycle
module lsu_top import lsu_pkg::*; #(
  parameter dword_t BASE_ADDR  = 64'h0000_0000_8000_0000,
  parameter int     DEPTH_LOG2 = 8
) (
  input  logic    clk,
  input  logic    i_rst,
  input  dword_t  i_addr,
  input  funct3_t i_funct3,
  input  logic    i_ren,
  input  logic    i_wen,
  input  dword_t  i_wdata,
  output logic    o_rvalid,
  output dword_t  o_rdata
);

  logic      ram_rvalid;
  dword_t    ram_rdata1;
  dword_t    ram_rdata2;
  byte_off_t ram_off;
  funct3_t   ram_funct3;

  mem_req_if #(.DEPTH_LOG2(DEPTH_LOG2)) req_if ();

  mem_align #(
    .BASE_ADDR (BASE_ADDR),
    .DEPTH_LOG2(DEPTH_LOG2)
  ) u_align (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_addr  (i_addr),
    .i_funct3(i_funct3),
    .i_ren   (i_ren),
    .i_wen   (i_wen),
    .i_wdata (i_wdata),
    .o_req   (req_if.src)
  );

  dual_word_ram #(
    .DEPTH_LOG2(DEPTH_LOG2)
  ) u_ram (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_req   (req_if.dst),
    .o_rvalid(ram_rvalid),
    .o_rdata1(ram_rdata1),
    .o_rdata2(ram_rdata2),
    .o_off   (ram_off),
    .o_funct3(ram_funct3)
  );

  load_extract u_extract (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_rvalid(ram_rvalid),
    .i_rdata1(ram_rdata1),
    .i_rdata2(ram_rdata2),
    .i_off   (ram_off),
    .i_funct3(ram_funct3),
    .o_rvalid(o_rvalid),
    .o_rdata (o_rdata)
  );

endmodule

// ==== tb_lsu_top.sv ====
// self-checking testbench; prefills and uses only the first 512 bytes above BASE_ADDR
module tb_lsu_top import lsu_pkg::*; ();

  localparam dword_t BASE    = 64'h0000_0000_8000_0000;
  localparam int     PREFILL = 64;
  localparam int     N_RAND  = 200;

  typedef struct packed {
    logic        wen;
    funct3_t     f3;
    logic [11:0] off;
    // store data, or the expected load result
    dword_t      data;
  } op_t;

  logic    clk;
  logic    i_rst;
  dword_t  i_addr;
  funct3_t i_funct3;
  logic    i_ren;
  logic    i_wen;
  dword_t  i_wdata;
  logic    o_rvalid;
  dword_t  o_rdata;

  op_t         table_q[$];
  dword_t      exp_q[$];
  logic [7:0]  model [512];
  logic [2:0]  ren_hist;
  logic [31:0] lfsr;
  logic        checking;
  int          cycles;
  int          limit;

  lsu_top #(.BASE_ADDR(BASE), .DEPTH_LOG2(8)) DUT (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_addr  (i_addr),
    .i_funct3(i_funct3),
    .i_ren   (i_ren),
    .i_wen   (i_wen),
    .i_wdata (i_wdata),
    .o_rvalid(o_rvalid),
    .o_rdata (o_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_error();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rdata(input dword_t got, input dword_t exp);
    if (got !== exp) begin
      $display("FAIL o_rdata got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rvalid(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL o_rvalid got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic dword_t lfsr_bits(input int n);
    dword_t r;
    logic   fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic void model_store(input logic [11:0] off, input funct3_t f3, input dword_t d);
    for (int i = 0; i < (1 << f3[1:0]); i++) begin
      model[int'(off) + i] = d[8*i +: 8];
    end
  endfunction

  function automatic dword_t model_load(input logic [11:0] off, input funct3_t f3);
    dword_t v;
    int     n;
    v = '0;
    n = 1 << f3[1:0];
    // little endian, so gather from the highest byte down
    for (int i = n - 1; i >= 0; i--) begin
      v = {v[55:0], model[int'(off) + i]};
    end
    // funct3[2] clear means signed
    if (!f3[2] && v[8*n-1]) begin
      v = v | (~64'd0 << (8 * n));
    end
    return v;
  endfunction

  function automatic void add_entry(input logic w, input funct3_t f3, input logic [11:0] off,
                                    input dword_t d);
    table_q.push_back({w, f3, off, d});
  endfunction

  function automatic void build_table();
    // aligned dword, then one byte at each offset
    add_entry(1'b1, F3_SD,  12'h100, 64'h0123_4567_89ab_cdef);
    add_entry(1'b0, F3_LD,  12'h100, 64'h0123_4567_89ab_cdef);
    add_entry(1'b1, F3_SB,  12'h100, 64'h5555_5555_5555_55a0);
    add_entry(1'b0, F3_LD,  12'h100, 64'h0123_4567_89ab_cda0);
    add_entry(1'b1, F3_SB,  12'h101, 64'h5555_5555_5555_55a1);
    add_entry(1'b0, F3_LD,  12'h100, 64'h0123_4567_89ab_a1a0);
    add_entry(1'b1, F3_SB,  12'h102, 64'h5555_5555_5555_55a2);
    add_entry(1'b0, F3_LD,  12'h100, 64'h0123_4567_89a2_a1a0);
    add_entry(1'b1, F3_SB,  12'h103, 64'h5555_5555_5555_55a3);
    add_entry(1'b0, F3_LD,  12'h100, 64'h0123_4567_a3a2_a1a0);
    add_entry(1'b1, F3_SB,  12'h104, 64'h5555_5555_5555_55a4);
    add_entry(1'b0, F3_LD,  12'h100, 64'h0123_45a4_a3a2_a1a0);
    add_entry(1'b1, F3_SB,  12'h105, 64'h5555_5555_5555_55a5);
    add_entry(1'b0, F3_LD,  12'h100, 64'h0123_a5a4_a3a2_a1a0);
    add_entry(1'b1, F3_SB,  12'h106, 64'h5555_5555_5555_55a6);
    add_entry(1'b0, F3_LD,  12'h100, 64'h01a6_a5a4_a3a2_a1a0);
    add_entry(1'b1, F3_SB,  12'h107, 64'h5555_5555_5555_55a7);
    add_entry(1'b0, F3_LD,  12'h100, 64'ha7a6_a5a4_a3a2_a1a0);
    // sign and zero extension of negative values
    add_entry(1'b1, F3_SD,  12'h108, 64'h1234_5678_9abc_def0);
    add_entry(1'b0, F3_LB,  12'h108, 64'hffff_ffff_ffff_fff0);
    add_entry(1'b0, F3_LBU, 12'h108, 64'h0000_0000_0000_00f0);
    add_entry(1'b0, F3_LH,  12'h108, 64'hffff_ffff_ffff_def0);
    add_entry(1'b0, F3_LHU, 12'h108, 64'h0000_0000_0000_def0);
    add_entry(1'b0, F3_LW,  12'h108, 64'hffff_ffff_9abc_def0);
    add_entry(1'b0, F3_LWU, 12'h108, 64'h0000_0000_9abc_def0);
    // accesses across the 0x118 and 0x120 word boundaries
    add_entry(1'b1, F3_SD,  12'h110, 64'h1716_1514_1312_1110);
    add_entry(1'b1, F3_SD,  12'h118, 64'h1f1e_1d1c_1b1a_1918);
    add_entry(1'b1, F3_SW,  12'h116, 64'hcccc_cccc_a3a2_a1a0);
    add_entry(1'b0, F3_LD,  12'h110, 64'ha1a0_1514_1312_1110);
    add_entry(1'b0, F3_LD,  12'h118, 64'h1f1e_1d1c_1b1a_a3a2);
    add_entry(1'b0, F3_LW,  12'h116, 64'hffff_ffff_a3a2_a1a0);
    add_entry(1'b1, F3_SH,  12'h11f, 64'h3333_3333_3333_b1b0);
    add_entry(1'b0, F3_LH,  12'h11f, 64'hffff_ffff_ffff_b1b0);
    add_entry(1'b0, F3_LD,  12'h118, 64'hb01e_1d1c_1b1a_a3a2);
    add_entry(1'b1, F3_SD,  12'h11b, 64'hc7c6_c5c4_c3c2_c1c0);
    add_entry(1'b0, F3_LD,  12'h11b, 64'hc7c6_c5c4_c3c2_c1c0);
    add_entry(1'b0, F3_LD,  12'h118, 64'hc4c3_c2c1_c01a_a3a2);
    add_entry(1'b0, F3_LHU, 12'h11f, 64'h0000_0000_0000_c5c4);
    // store, then back-to-back loads on the same bytes
    add_entry(1'b1, F3_SD,  12'h11b, 64'h1122_3344_5566_7788);
    add_entry(1'b0, F3_LD,  12'h11b, 64'h1122_3344_5566_7788);
    add_entry(1'b0, F3_LWU, 12'h11f, 64'h0000_0000_1122_3344);
  endfunction

  task automatic issue(input op_t op);
    @(posedge clk);
    i_ren    <= !op.wen;
    i_wen    <= op.wen;
    i_funct3 <= op.f3;
    i_addr   <= BASE + {52'd0, op.off};
    i_wdata  <= op.wen ? op.data : '0;
    if (op.wen) begin
      model_store(op.off, op.f3, op.data);
    end else begin
      exp_q.push_back(op.data);
    end
  endtask

  // rvalid must follow each accepted load by three edges
  always @(negedge clk) begin
    if (checking) begin
      cycles++;
      if (cycles > limit) begin
        $display("timeout: the run did not finish within %0d cycles", limit);
        stop_on_error();
      end
      if (o_rvalid !== ren_hist[2]) begin
        if (ren_hist[2]) begin
          $display("a load got no o_rvalid three cycles after it was issued");
        end else begin
          $display("o_rvalid came with no load issued three cycles earlier");
        end
        stop_on_error();
      end
      if (o_rvalid) begin
        check_rdata(o_rdata, exp_q.pop_front());
      end
      ren_hist = {ren_hist[1:0], i_ren};
    end
  end

  initial begin
    op_t        op;
    dword_t     a;
    logic [2:0] f3_bits;
    i_rst    = 1'b1;
    i_addr   = BASE;
    i_funct3 = F3_LD;
    i_ren    = 1'b0;
    i_wen    = 1'b0;
    i_wdata  = '0;
    ren_hist = '0;
    checking = 1'b0;
    cycles   = 0;
    lfsr     = 32'hd64;
    build_table();
    limit = PREFILL + table_q.size() + N_RAND + 20;
    repeat (7) @(posedge clk);
    // load result and valid come out of reset cleared
    @(negedge clk);
    check_rvalid(o_rvalid, 1'b0);
    check_rdata(o_rdata, '0);
    @(posedge clk);
    i_rst <= 1'b0;
    checking = 1'b1;
    // every word gets a value tied to its full address
    for (int w = 0; w < PREFILL; w++) begin
      a  = BASE + 64'(8 * w);
      op = {1'b1, F3_SD, 12'(8 * w), a ^ {a[31:0], a[63:32]} ^ 64'h9e37_79b9_7f4a_7c15};
      issue(op);
    end
    foreach (table_q[k]) begin
      issue(table_q[k]);
    end
    for (int r = 0; r < N_RAND; r++) begin
      op.wen = 1'(lfsr_bits(1));
      op.off = 12'(lfsr_bits(8));
      if (op.wen) begin
        op.f3   = funct3_t'({1'b0, 2'(lfsr_bits(2))});
        op.data = lfsr_bits(64);
      end else begin
        f3_bits = 3'(lfsr_bits(3));
        // 3'b111 is no load, fold onto LD
        if (f3_bits == 3'b111) begin
          f3_bits = 3'b011;
        end
        op.f3   = funct3_t'(f3_bits);
        op.data = model_load(op.off, op.f3);
      end
      issue(op);
    end
    @(posedge clk);
    i_ren <= 1'b0;
    i_wen <= 1'b0;
    // fixed three-cycle latency, so the pipe is empty after this
    repeat (4) @(posedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== lsu_top.f ====
lsu_pkg.sv
mem_req_if.sv
mem_align.sv
dual_word_ram.sv
load_extract.sv
lsu_top.sv
tb_lsu_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_lsu_top
FILELIST   := lsu_top.f
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing --assert
SIM_FLAGS  := --binary --assert -Wno-fatal -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
